//--- verilog/tmds_consts.svh
// TMDS channel sync constants
// widths, run lengths and the loss timer limit for the word aligner
`ifndef TMDS_CONSTS_SVH
`define TMDS_CONSTS_SVH

////////////////////
// symbol geometry
`define TMDS_WORD_W     10  // one channel symbol
`define TMDS_OFS_W      4   // bit offset 0..9

////////////////////
// lock criteria
`define TMDS_CTRL_RUN   12  // control symbols needed ahead of a guard
`define TMDS_CONFIRM    4   // same-offset matches before accepting

// cycles without a confirming guard before sync is dropped
`define TMDS_LOSS_LIMIT 255

`endif

//--- verilog/tmds_pkg.sv
// TMDS channel sync types
// word, window, offset and lock state types shared by the aligner blocks
`include "tmds_consts.svh"

package tmds_pkg;

	// one raw or aligned channel word
	typedef logic [`TMDS_WORD_W-1:0]   tmds_word_t;

	// prev word low bits on top, current word below
	typedef logic [2*`TMDS_WORD_W-2:0] tmds_window_t;

	typedef logic [`TMDS_OFS_W-1:0]    tmds_offset_t;  // bit slip 0..9

	typedef logic [`TMDS_WORD_W-1:0]   tmds_onehot_t;  // one bit per offset

	// offset lock FSM states
	typedef enum logic [1:0] {
		HUNT,     // nothing seen yet
		CONFIRM,  // counting a candidate
		LOCKED,   // offset in use
		RETRY     // still locked, testing a new candidate
	} lock_state_t;

endpackage

//--- verilog/tmds_pattern_scan.sv
// TMDS pattern scan
// keeps a two-word bit window and tests all ten bit offsets for a run of
// control symbols followed by a guard symbol; a match is reported only
// when exactly one offset hits
`include "tmds_consts.svh"

module tmds_pattern_scan
	import tmds_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_reset,
	input  tmds_word_t   i_px,
	output tmds_window_t o_window,
	output logic         o_match,
	output tmds_offset_t o_match_ofs
);

	// control and guard symbols as seen on the wire
	localparam tmds_word_t CTRL_0  = 10'h0ab;
	localparam tmds_word_t CTRL_1  = 10'h354;
	localparam tmds_word_t CTRL_2  = 10'h0aa;
	localparam tmds_word_t CTRL_3  = 10'h355;
	localparam tmds_word_t GUARD_0 = 10'h0cd;
	localparam tmds_word_t GUARD_1 = 10'h332;

	tmds_window_t r_window;
	tmds_onehot_t w_ctrl, w_guard;   // per offset, from the window
	tmds_onehot_t r_ctrl, r_guard;   // registered flags
	tmds_onehot_t r_hit;             // guard after a long enough run
	logic [4:0]   r_run [`TMDS_WORD_W];  // saturates at 16
	tmds_offset_t w_ofs;
	logic         r_match;
	tmds_offset_t r_match_ofs;

	////////////////////
	// window, edge n
	always_ff @(posedge i_clk)
		r_window <= {r_window[`TMDS_WORD_W-2:0], i_px};

	// symbol compare at every bit offset
	genvar k;
	generate for (k = 0; k < `TMDS_WORD_W; k = k + 1) begin : g_ofs
		tmds_word_t w_cand;

		assign w_cand = r_window[k +: `TMDS_WORD_W];  // bits k..k+9
		assign w_ctrl[k] = (w_cand == CTRL_0) || (w_cand == CTRL_1)
			|| (w_cand == CTRL_2) || (w_cand == CTRL_3);
		assign w_guard[k] = (w_cand == GUARD_0) || (w_cand == GUARD_1);
	end endgenerate

	// flags, edge n+1
	always_ff @(posedge i_clk) begin
		r_ctrl  <= w_ctrl;
		r_guard <= w_guard;
	end

	////////////////////
	// run counters and hits, edge n+2
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_hit <= '0;
			for (int i = 0; i < `TMDS_WORD_W; i++)
				r_run[i] <= '0;
		end else begin
			for (int i = 0; i < `TMDS_WORD_W; i++) begin
				// run count still covers only the words before this one
				r_hit[i] <= r_guard[i] && (r_run[i] >= 5'(`TMDS_CTRL_RUN));
				if (!r_ctrl[i])
					r_run[i] <= '0;  // broken run
				else if (!r_run[i][4])
					r_run[i] <= r_run[i] + 1'b1;
			end
		end
	end

	// encode hit index, only meaningful for one-hot
	always_comb begin
		w_ofs = '0;
		for (int i = 0; i < `TMDS_WORD_W; i++)
			if (r_hit[i])
				w_ofs = w_ofs | tmds_offset_t'(i);
	end

	////////////////////
	// match strobe, edge n+3
	always_ff @(posedge i_clk) begin
		if (i_reset)
			r_match <= 1'b0;
		else
			r_match <= $onehot(r_hit);  // none or several hits rejected
	end

	always_ff @(posedge i_clk)
		r_match_ofs <= w_ofs;

	assign o_window    = r_window;
	assign o_match     = r_match;
	assign o_match_ofs = r_match_ofs;

endmodule

//--- verilog/tmds_lock_fsm.sv
// TMDS offset lock FSM
// filters match offsets into a chosen offset and a sync flag, with
// confirmation of new offsets and loss of lock on timer expiry
`include "tmds_consts.svh"

module tmds_lock_fsm
	import tmds_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_reset,
	input  logic         i_match,
	input  tmds_offset_t i_match_ofs,
	input  logic         i_expired,
	output tmds_offset_t o_chosen_ofs,
	output logic         o_sync_valid,
	output logic         o_refresh,
	output logic         o_restart
);

	localparam int CNT_W = $clog2(`TMDS_CONFIRM + 1);

	lock_state_t  r_state;
	tmds_offset_t r_chosen;
	tmds_offset_t r_cand;       // offset under test
	logic [CNT_W-1:0] r_cnt;    // matches seen at r_cand
	logic         w_is_cand, w_is_chosen, w_done;

	assign w_is_cand   = i_match && (i_match_ofs == r_cand);
	assign w_is_chosen = i_match && (i_match_ofs == r_chosen);
	assign w_done      = w_is_cand && (r_cnt == CNT_W'(`TMDS_CONFIRM - 1));

	assign o_sync_valid = (r_state == LOCKED) || (r_state == RETRY);

	// strobes reach the timer in the match cycle, so it is clear on lock entry
	assign o_restart = w_done && ((r_state == CONFIRM) || (r_state == RETRY));
	assign o_refresh = w_is_chosen && o_sync_valid;

	////////////////////
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_state  <= HUNT;
			r_chosen <= '0;
			r_cand   <= '0;
			r_cnt    <= '0;
		end else if (i_expired && o_sync_valid) begin
			r_state <= HUNT;  // no guard seen for too long
		end else if (i_match) begin
			case (r_state)
			HUNT: begin
				r_cand  <= i_match_ofs;
				r_cnt   <= CNT_W'(1);
				r_state <= CONFIRM;
			end
			CONFIRM, RETRY: begin
				if (w_done) begin
					r_chosen <= r_cand;  // adopt
					r_state  <= LOCKED;
				end else if ((r_state == RETRY) && w_is_chosen) begin
					r_state <= LOCKED;  // old offset is back
				end else if (w_is_cand) begin
					r_cnt <= r_cnt + 1'b1;
				end else begin
					r_cand <= i_match_ofs;  // restart count on new candidate
					r_cnt  <= CNT_W'(1);
				end
			end
			LOCKED: begin
				if (!w_is_chosen) begin
					r_cand  <= i_match_ofs;
					r_cnt   <= CNT_W'(1);
					r_state <= RETRY;
				end
			end
			default: r_state <= HUNT;
			endcase
		end
	end

	assign o_chosen_ofs = r_chosen;

endmodule

//--- verilog/tmds_loss_timer.sv
// TMDS loss timer
// saturating count of cycles since the last confirming guard match;
// starts expired so the channel comes up out of sync
`include "tmds_consts.svh"

module tmds_loss_timer (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_refresh,
	input  logic i_restart,
	output logic o_expired
);

	localparam int LOSS_W = $clog2(`TMDS_LOSS_LIMIT + 1);
	localparam logic [LOSS_W-1:0] LIMIT = LOSS_W'(`TMDS_LOSS_LIMIT);

	logic [LOSS_W-1:0] r_count;

	////////////////////
	always_ff @(posedge i_clk) begin
		if (i_reset)
			r_count <= LIMIT;  // out of sync from the start
		else if (i_refresh || i_restart)
			r_count <= '0;
		else if (r_count != LIMIT)
			r_count <= r_count + 1'b1;  // holds at the limit
	end

	// level, stays up until the next refresh or restart
	assign o_expired = (r_count == LIMIT);

endmodule

//--- verilog/tmds_word_shifter.sv
// TMDS word shifter
// ten-way barrel shift of the bit window by the chosen offset into a
// registered output word
`include "tmds_consts.svh"

module tmds_word_shifter
	import tmds_pkg::*;
(
	input  logic         i_clk,
	input  tmds_window_t i_window,
	input  tmds_offset_t i_ofs,
	output tmds_word_t   o_pix
);

	tmds_word_t w_sel;
	tmds_word_t r_pix;

	// pick bits ofs..ofs+9 of the window
	always_comb begin
		w_sel = '0;  // offsets above 9 never chosen
		for (int k = 0; k < `TMDS_WORD_W; k++)
			if (i_ofs == tmds_offset_t'(k))
				w_sel = i_window[k +: `TMDS_WORD_W];
	end

	// data only, one cycle behind the window
	always_ff @(posedge i_clk)
		r_pix <= w_sel;

	assign o_pix = r_pix;

endmodule

//--- verilog/tmds_channel_sync.sv
// TMDS channel sync
// word aligner for one colour channel: pattern scan, lock FSM, loss
// timer and output shifter
module tmds_channel_sync
	import tmds_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_reset,
	input  tmds_word_t   i_px,
	output tmds_word_t   o_pix,
	output tmds_offset_t o_offset,
	output logic         o_sync_valid,
	output logic         o_match
);

	tmds_window_t w_window;
	logic         w_match;
	tmds_offset_t w_match_ofs;
	tmds_offset_t w_chosen_ofs;
	logic         w_refresh, w_restart;  // strobes to the timer
	logic         w_expired;             // level back to the FSM

	////////////////////
	tmds_pattern_scan u_scan (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_px        (i_px),
		.o_window    (w_window),
		.o_match     (w_match),
		.o_match_ofs (w_match_ofs)
	);

	tmds_lock_fsm u_fsm (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_match      (w_match),
		.i_match_ofs  (w_match_ofs),
		.i_expired    (w_expired),
		.o_chosen_ofs (w_chosen_ofs),
		.o_sync_valid (o_sync_valid),
		.o_refresh    (w_refresh),
		.o_restart    (w_restart)
	);

	tmds_loss_timer u_timer (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_refresh (w_refresh),
		.i_restart (w_restart),
		.o_expired (w_expired)
	);

	tmds_word_shifter u_shift (
		.i_clk    (i_clk),
		.i_window (w_window),
		.i_ofs    (w_chosen_ofs),
		.o_pix    (o_pix)
	);

	assign o_offset = w_chosen_ofs;
	assign o_match  = w_match;  // raw single-offset guard strobe

endmodule

//--- tests/tb_clock.sv
// testbench clock and reset
// 10 ns clock, reset held high for the first 16 rising edges
module tb_clock (
	output logic o_clk,
	output logic o_reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;  // 10 ns period
	end

	initial begin
		o_reset = 1'b1;
		repeat (16) @(posedge o_clk);
		o_reset <= 1'b0;  // released on an edge like the other inputs
	end

endmodule

//--- tests/tmds_channel_sync_chk.sv
// TMDS channel sync checker
// concurrent assertions on offset range, offset stability while in sync
// and the minimum number of guard matches before first lock
`include "tmds_consts.svh"

module tmds_channel_sync_chk (
	input logic       i_clk,
	input logic       i_reset,
	input logic [3:0] i_offset,
	input logic       i_sync_valid,
	input logic       i_match,
	input logic       i_restart
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [3:0] r_seen;  // matches since reset, saturating

	always_ff @(posedge i_clk) begin
		if (i_reset)
			r_seen <= '0;
		else if (i_match && (r_seen < 4'(`TMDS_CONFIRM)))
			r_seen <= r_seen + 1'b1;
	end

	////////////////////
	// offset always one of the ten slips
	a_ofs_range: assert property (@(posedge i_clk) disable iff (i_reset)
		i_offset < 4'd10)
		else $error("offset out of range");

	// offset moves only out of sync or on an accepted candidate
	a_ofs_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		$changed(i_offset) |-> (!$past(i_sync_valid) || $past(i_restart)))
		else $error("offset changed while in sync");

	// no lock before enough guard matches
	a_early_lock: assert property (@(posedge i_clk) disable iff (i_reset)
		i_sync_valid |-> (r_seen >= 4'(`TMDS_CONFIRM)))
		else $error("sync valid before enough matches");

endmodule

//--- tests/tmds_channel_sync_tb.sv
// TMDS channel sync testbench
// table-driven serial stream with bit slip, software window model and
// checks of lock, offset and aligned words
`include "tmds_consts.svh"

module tmds_channel_sync_tb
	import tmds_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam tmds_word_t SYM_CTRL  = 10'h354;
	localparam tmds_word_t SYM_GUARD = 10'h0cd;
	localparam int MAX_ROWS = 64;

	logic i_clk, i_reset;
	tmds_word_t i_px, o_pix;
	tmds_offset_t o_offset;
	logic o_sync_valid, o_match;

	// stimulus table, one row per blanking period
	int t_slip [MAX_ROWS];
	int t_ctrl [MAX_ROWS];
	int t_guard[MAX_ROWS];
	int t_data [MAX_ROWS];
	bit t_gap  [MAX_ROWS];
	bit t_lock [MAX_ROWS];
	int t_ofs  [MAX_ROWS];
	int n_rows;

	integer seed;
	int errors, checks, cycles, limit, phase;
	bit quiet;              // no sync or match allowed this row
	int n_match;            // o_match pulses seen this row
	bit q[$];               // serial bits, oldest first
	tmds_word_t sym_q[$];   // symbols sent this row
	tmds_word_t out_q[$];   // o_pix seen this row
	logic [2*`TMDS_WORD_W-2:0] m_win;  // model window
	int m_run[`TMDS_WORD_W];
	int m_matches, m_ofs;

	tb_clock u_clk (.o_clk(i_clk), .o_reset(i_reset));

	tmds_channel_sync tmds_channel_sync_inst (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_px         (i_px),
		.o_pix        (o_pix),
		.o_offset     (o_offset),
		.o_sync_valid (o_sync_valid),
		.o_match      (o_match)
	);

	bind tmds_channel_sync tmds_channel_sync_chk chk_inst (
		.i_clk(i_clk), .i_reset(i_reset), .i_offset(o_offset),
		.i_sync_valid(o_sync_valid), .i_match(o_match), .i_restart(w_restart)
	);

	function automatic bit is_ctrl(input tmds_word_t w);
		return (w == 10'h0ab) || (w == 10'h354) || (w == 10'h0aa) || (w == 10'h355);
	endfunction

	function automatic bit is_guard(input tmds_word_t w);
		return (w == 10'h0cd) || (w == 10'h332);
	endfunction

	// slip s delays the stream, symbol lands at window bit 10-s
	function automatic int ofs_for(input int s);
		return (10 - s) % 10;
	endfunction

	function tmds_word_t rand_data();
		tmds_word_t w;
		do
			w = tmds_word_t'($random(seed));
		while (is_ctrl(w) || is_guard(w));  // data never mimics blanking
		return w;
	endfunction

	task automatic add_row(input int slip, input int ctrl, input int guard,
		input int data, input bit gap, input bit lock, input int ofs);
		t_slip[n_rows]  = slip;
		t_ctrl[n_rows]  = ctrl;
		t_guard[n_rows] = guard;
		t_data[n_rows]  = data;
		t_gap[n_rows]   = gap;
		t_lock[n_rows]  = lock;
		t_ofs[n_rows]   = ofs;
		n_rows++;
	endtask

	////////////////////
	// table
	task automatic build_table();
		n_rows = 0;
		add_row(0, 0, 0, 20, 0, 0, 0);  // data only through reset
		for (int i = 0; i < 4; i++)
			add_row(3, 11, 1, 10, 0, 0, 0);  // run one short
		for (int s = 0; s < 10; s++)
			for (int i = 0; i < 4; i++)
				add_row(s, 12, 1, 10, 0, (s > 0) || (i == 3),
					(i == 3) ? ofs_for(s) : ofs_for((s + 9) % 10));
		add_row(9, 12, 2, 10, 0, 1, ofs_for(9));
		add_row(9, 14, 1, 12, 0, 1, ofs_for(9));
		add_row(5, 12, 1, 10, 0, 1, ofs_for(9));  // lone period elsewhere
		add_row(9, 12, 1, 10, 0, 1, ofs_for(9));
		add_row(9, 0, 0, 300, 1, 0, 0);  // loss of sync
		for (int i = 0; i < 4; i++)
			add_row(7, 12, 1, 10, 0, i == 3, ofs_for(7));
		add_row(7, 13, 1, 12, 0, 1, ofs_for(7));
		add_row(7, 12, 3, 10, 0, 1, ofs_for(7));
	endtask

	////////////////////
	// software window and matching rule
	task automatic model_step(input tmds_word_t w);
		int hits;
		int hk;
		tmds_word_t c;
		hits = 0;
		hk = 0;
		m_win = {m_win[`TMDS_WORD_W-2:0], w};
		for (int k = 0; k < `TMDS_WORD_W; k++) begin
			c = m_win[k +: `TMDS_WORD_W];
			if (is_guard(c) && (m_run[k] >= `TMDS_CTRL_RUN)) begin
				hits++;
				hk = k;
			end
			if (!is_ctrl(c))
				m_run[k] = 0;
			else if (m_run[k] < 16)
				m_run[k]++;
		end
		if (hits == 1) begin
			m_matches++;
			m_ofs = hk;
		end
	endtask

	task automatic send_word(input tmds_word_t w);
		@(posedge i_clk);
		i_px <= w;
		model_step(w);
	endtask

	// msb first onto the wire, words cut as bits come
	task automatic push_sym(input tmds_word_t s);
		tmds_word_t w;
		sym_q.push_back(s);
		for (int b = `TMDS_WORD_W - 1; b >= 0; b--)
			q.push_back(s[b]);
		while (q.size() >= `TMDS_WORD_W) begin
			for (int b = `TMDS_WORD_W - 1; b >= 0; b--)
				w[b] = q.pop_front();
			send_word(w);
		end
	endtask

	task automatic set_slip(input int s);
		repeat ((s - phase + 10) % 10) q.push_back(1'b0);  // filler bits
		phase = s;
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		checks++;
		assert (got == exp)
			else begin
				errors++;
				$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
			end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond)
			else begin
				errors++;
				$display("error at t=%0t: %s", $time, what);
			end
	endtask

	// aligned words against sent symbols, from the first guard on
	task automatic compare_stream();
		int si;
		int oi;
		si = -1;
		oi = -1;
		foreach (sym_q[i])
			if (si < 0 && is_guard(sym_q[i]))
				si = i;
		foreach (out_q[i])
			if (oi < 0 && !$isunknown(out_q[i]) && is_guard(out_q[i]))
				oi = i;
		check_true(oi >= 0, "no guard symbol seen on o_pix while locked");
		if (oi >= 0 && si >= 0)
			for (int i = 0; (si + i < sym_q.size()) && (oi + i < out_q.size()); i++)
				check_val("o_pix", out_q[oi + i], sym_q[si + i]);
	endtask

	// outputs sampled away from the driving edge
	always @(negedge i_clk) begin
		out_q.push_back(o_pix);
		if (o_match === 1'b1)
			n_match++;
		if (quiet) begin
			check_val("o_sync_valid", o_sync_valid, 0);
			check_val("o_match", o_match, 0);
		end
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, stimulus did not complete", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////
	// main sequence
	initial begin
		int words;
		i_px = '0;
		seed = 32'h360c;
		errors = 0;
		checks = 0;
		cycles = 0;
		phase = 0;
		quiet = 1'b0;
		n_match = 0;
		m_win = '0;
		m_matches = 0;
		m_ofs = 0;
		foreach (m_run[k])
			m_run[k] = 0;
		build_table();
		words = 0;
		for (int r = 0; r < n_rows; r++)
			words += t_ctrl[r] + t_guard[r] + t_data[r] + 1;  // +1 for filler
		limit = words + 2 * `TMDS_LOSS_LIMIT + 100;

		for (int r = 0; r < n_rows; r++) begin
			quiet = !t_gap[r] && (t_ctrl[r] < `TMDS_CTRL_RUN);
			set_slip(t_slip[r]);
			sym_q.delete();
			out_q.delete();
			m_matches = 0;
			n_match = 0;
			if (t_gap[r]) begin
				repeat (t_ctrl[r] + t_guard[r] + t_data[r]) push_sym(rand_data());
			end else begin
				repeat (t_ctrl[r]) push_sym(SYM_CTRL);
				repeat (t_guard[r]) push_sym(SYM_GUARD);
				repeat (t_data[r]) push_sym(rand_data());
			end
			@(negedge i_clk);

			// model offset from the slip geometry
			if (!t_gap[r] && t_ctrl[r] >= `TMDS_CTRL_RUN) begin
				check_true(m_matches > 0, "model found no guard match in a blanking row");
				check_val("model offset", m_ofs, ofs_for(t_slip[r]));
			end else begin
				check_val("model matches", m_matches, 0);
			end
			check_val("o_match pulses", n_match, m_matches);

			check_val("o_sync_valid", o_sync_valid, t_lock[r]);
			if (t_lock[r])
				check_val("o_offset", o_offset, t_ofs[r]);
			// offset already in use for the whole row
			if (r > 0 && t_lock[r] && t_lock[r-1] && !t_gap[r]
				&& t_slip[r] == t_slip[r-1] && t_ofs[r] == ofs_for(t_slip[r])
				&& t_ofs[r-1] == t_ofs[r])
				compare_stream();
		end
		quiet = 1'b0;

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+verilog
verilog/tmds_pkg.sv
verilog/tmds_pattern_scan.sv
verilog/tmds_lock_fsm.sv
verilog/tmds_loss_timer.sv
verilog/tmds_word_shifter.sv
verilog/tmds_channel_sync.sv
tests/tb_clock.sv
tests/tmds_channel_sync_chk.sv
tests/tmds_channel_sync_tb.sv

//--- run.sh
#!/bin/sh
# build and run the TMDS channel sync testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f sim.f --top-module tmds_channel_sync_tb -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
